// ==== include/iobuf_helper.svh ====
`ifndef IOBUF_HELPER_SVH
`define IOBUF_HELPER_SVH

// Board resistor DAC pads are open-drain style:
// a set bit drives the pin high, a clear bit releases it to high-Z
// so the resistor network pulls that leg down.

// Level a released pin takes
`define IOBUF_RELEASED 1'bz

// Level a driven pin takes
`define IOBUF_DRIVEN 1'b1

// Value for one pad, used on the right side of a continuous assignment
`define IOBUF_DRIVE_HIGH(bit_val) ((bit_val) ? `IOBUF_DRIVEN : `IOBUF_RELEASED)

`endif

// ==== logic/vga_timing_pkg.sv ====
package vga_timing_pkg;

    // Horizontal phases, in pixel clocks
    localparam int H_VISIBLE = 16;
    localparam int H_FRONT   = 2;
    localparam int H_SYNC    = 3;
    localparam int H_BACK    = 3;

    // Vertical phases, in lines
    localparam int V_VISIBLE = 8;
    localparam int V_FRONT   = 1;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 1;

    localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

    // Sync windows, start inclusive and end exclusive
    localparam int H_SYNC_START = H_VISIBLE + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int V_SYNC_START = V_VISIBLE + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    // Sync pulses go low during the sync phase
    localparam logic SYNC_ACTIVE_LOW = 1'b1;

    // Counter widths, enough for H_TOTAL and V_TOTAL
    localparam int X_W = 5;
    localparam int Y_W = 4;

    typedef struct packed {
        logic [X_W-1:0] x;
        logic [Y_W-1:0] y;
        logic           visible;
        logic           hsync;
        logic           vsync;
    } scan_pos_t;

endpackage

// ==== logic/vga_color_pkg.sv ====
package vga_color_pkg;

    typedef logic [5:0] level6_t;
    typedef logic [3:0] level4_t;

    typedef struct packed {
        level6_t red;
        level6_t green;
        level6_t blue;
    } rgb18_t;

    typedef enum logic [1:0] {
        PAT_SOLID,
        PAT_BARS,
        PAT_GRADIENT,
        PAT_CHECKER
    } pattern_sel_t;

    localparam int CHANNELS = 3;

    localparam level6_t LEVEL6_MAX = 6'h3F;
    localparam level4_t LEVEL4_MAX = 4'hF;

    localparam rgb18_t RGB_WHITE = '{red: LEVEL6_MAX, green: LEVEL6_MAX, blue: LEVEL6_MAX};
    localparam rgb18_t RGB_BLACK = '{red: 6'h00, green: 6'h00, blue: 6'h00};

    // 2x2 ordered dither thresholds, indexed [y][x]
    localparam logic [1:0] BAYER2 [0:1][0:1] = '{
        '{2'd0, 2'd2},
        '{2'd3, 2'd1}
    };

endpackage

// ==== logic/vga_timing.sv ====
`timescale 1ns/1ns

module vga_timing import vga_timing_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    output scan_pos_t pos_o
);

    logic [X_W-1:0] x_q;
    logic [Y_W-1:0] y_q;
    logic           line_end;
    logic           frame_end;
    logic           in_hsync;
    logic           in_vsync;

    assign line_end  = (int'(x_q) == H_TOTAL - 1);
    assign frame_end = (int'(y_q) == V_TOTAL - 1);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            x_q <= '0;
            y_q <= '0;
        end else if (line_end) begin
            x_q <= '0;
            // Step to the next line, wrap at frame end
            if (frame_end) begin
                y_q <= '0;
            end else begin
                y_q <= y_q + 1'b1;
            end
        end else begin
            x_q <= x_q + 1'b1;
        end
    end

    assign in_hsync = (int'(x_q) >= H_SYNC_START) && (int'(x_q) < H_SYNC_END);
    assign in_vsync = (int'(y_q) >= V_SYNC_START) && (int'(y_q) < V_SYNC_END);

    always_comb begin
        pos_o.x       = x_q;
        pos_o.y       = y_q;
        pos_o.visible = (int'(x_q) < H_VISIBLE) && (int'(y_q) < V_VISIBLE);
        // Polarity flip for active-low syncs
        pos_o.hsync   = SYNC_ACTIVE_LOW ^ in_hsync;
        pos_o.vsync   = SYNC_ACTIVE_LOW ^ in_vsync;
    end

    x_in_range: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        int'(x_q) < H_TOTAL
    ) else $error("x counter left the line range");

    // Vertical sync edges only at the first pixel of a line
    vsync_at_line_start: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $changed(pos_o.vsync) |-> (x_q == '0)
    ) else $error("vsync changed in the middle of a line");

endmodule

// ==== logic/vga_pattern_source.sv ====
`timescale 1ns/1ns

module vga_pattern_source import vga_timing_pkg::*, vga_color_pkg::*; (
    input  logic         clk,
    input  logic         rst_n_i,
    input  scan_pos_t    pos_i,
    input  pattern_sel_t pattern_sel_i,
    input  rgb18_t       solid_color_i,
    output scan_pos_t    pos_o,
    output rgb18_t       color_o
);

    rgb18_t     color_d;
    logic [2:0] bar_idx;
    logic [5:0] x_ramp;

    // Eight bars, two pixels wide
    assign bar_idx = pos_i.x[3:1];
    assign x_ramp  = {pos_i.x[3:0], 2'b00};

    always_comb begin
        color_d = solid_color_i;
        case (pattern_sel_i)
            PAT_SOLID: begin
                color_d = solid_color_i;
            end
            PAT_BARS: begin
                // Red on bit 2, green on bit 1, blue on bit 0
                color_d.red   = bar_idx[2] ? LEVEL6_MAX : '0;
                color_d.green = bar_idx[1] ? LEVEL6_MAX : '0;
                color_d.blue  = bar_idx[0] ? LEVEL6_MAX : '0;
            end
            PAT_GRADIENT: begin
                color_d.red   = x_ramp;
                color_d.green = {pos_i.y[2:0], 3'b000};
                color_d.blue  = LEVEL6_MAX - x_ramp;
            end
            PAT_CHECKER: begin
                color_d = (pos_i.x[1] ^ pos_i.y[1]) ? RGB_WHITE : RGB_BLACK;
            end
        endcase
    end

    // Position is cleared to a blanked, sync-idle state
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pos_o.x       <= '0;
            pos_o.y       <= '0;
            pos_o.visible <= 1'b0;
            pos_o.hsync   <= SYNC_ACTIVE_LOW;
            pos_o.vsync   <= SYNC_ACTIVE_LOW;
        end else begin
            pos_o <= pos_i;
        end
    end

    always_ff @(posedge clk) begin
        color_o <= color_d;
    end

endmodule

// ==== logic/vga_dither_channel.sv ====
`timescale 1ns/1ns

module vga_dither_channel import vga_timing_pkg::*, vga_color_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  level6_t   level_i,
    input  scan_pos_t pos_i,
    output level4_t   level_o
);

    logic [1:0] thresh;
    logic       bump;
    logic [4:0] sum;
    level4_t    level_d;

    // Threshold from the pixel's place in the 2x2 cell
    assign thresh = BAYER2[pos_i.y[0]][pos_i.x[0]];
    assign bump   = (level_i[1:0] > thresh);

    always_comb begin
        sum = {1'b0, level_i[5:2]} + {4'b0000, bump};
        if (!pos_i.visible) begin
            level_d = '0;
        end else if (sum[4]) begin
            // Top code stays at full scale
            level_d = LEVEL4_MAX;
        end else begin
            level_d = sum[3:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            level_o <= '0;
        end else begin
            level_o <= level_d;
        end
    end

    blank_outside_visible: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !$past(pos_i.visible) |-> (level_o == '0)
    ) else $error("DAC level nonzero outside the visible area");

endmodule

// ==== logic/vga_pad_bank.sv ====
`timescale 1ns/1ns

`include "iobuf_helper.svh"

module vga_pad_bank import vga_timing_pkg::*, vga_color_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  level4_t    red_i,
    input  level4_t    green_i,
    input  level4_t    blue_i,
    input  logic       hsync_i,
    input  logic       vsync_i,
    inout  wire  [3:0] vga_r_io,
    inout  wire  [3:0] vga_g_io,
    inout  wire  [3:0] vga_b_io,
    output logic       vga_hsync_o,
    output logic       vga_vsync_o
);

    logic [1:0] hsync_q;
    logic [1:0] vsync_q;

    // Two stages to match pattern and dither latency
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            hsync_q <= {2{SYNC_ACTIVE_LOW}};
            vsync_q <= {2{SYNC_ACTIVE_LOW}};
        end else begin
            hsync_q <= {hsync_q[0], hsync_i};
            vsync_q <= {vsync_q[0], vsync_i};
        end
    end

    assign vga_hsync_o = hsync_q[1];
    assign vga_vsync_o = vsync_q[1];

    // One pad per DAC leg
    for (genvar i = 0; i < $bits(level4_t); i++) begin : g_pin
        assign vga_r_io[i] = `IOBUF_DRIVE_HIGH(red_i[i]);
        assign vga_g_io[i] = `IOBUF_DRIVE_HIGH(green_i[i]);
        assign vga_b_io[i] = `IOBUF_DRIVE_HIGH(blue_i[i]);
    end

endmodule

// ==== logic/vga_display_top.sv ====
`timescale 1ns/1ns

module vga_display_top import vga_timing_pkg::*, vga_color_pkg::*; (
    input  logic         clk,
    input  logic         rst_n_i,
    input  pattern_sel_t pattern_sel_i,
    input  rgb18_t       solid_color_i,
    // DAC legs are inout for high-Z drive
    inout  wire  [3:0]   vga_r_io,
    inout  wire  [3:0]   vga_g_io,
    inout  wire  [3:0]   vga_b_io,
    output logic         vga_hsync_o,
    output logic         vga_vsync_o
);

    scan_pos_t scan_pos;
    scan_pos_t pix_pos;
    rgb18_t    pix_color;
    level6_t   chan_level [CHANNELS];
    level4_t   chan_out   [CHANNELS];

    vga_timing u_timing (
        .clk,
        .rst_n_i,
        .pos_o   (scan_pos)
    );

    vga_pattern_source u_pattern (
        .clk,
        .rst_n_i,
        .pos_i         (scan_pos),
        .pattern_sel_i,
        .solid_color_i,
        .pos_o         (pix_pos),
        .color_o       (pix_color)
    );

    // Channel 0 red, 1 green, 2 blue
    assign chan_level[0] = pix_color.red;
    assign chan_level[1] = pix_color.green;
    assign chan_level[2] = pix_color.blue;

    for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_chan
        vga_dither_channel u_dither (
            .clk,
            .rst_n_i,
            .level_i (chan_level[ch]),
            .pos_i   (pix_pos),
            .level_o (chan_out[ch])
        );
    end

    vga_pad_bank u_pads (
        .clk,
        .rst_n_i,
        .red_i       (chan_out[0]),
        .green_i     (chan_out[1]),
        .blue_i      (chan_out[2]),
        .hsync_i     (scan_pos.hsync),
        .vsync_i     (scan_pos.vsync),
        .vga_r_io,
        .vga_g_io,
        .vga_b_io,
        .vga_hsync_o,
        .vga_vsync_o
    );

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// ==== test/vga_scoreboard.sv ====
`timescale 1ns/1ns

module vga_scoreboard import vga_timing_pkg::*, vga_color_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  pattern_sel_t pattern_sel_i,
    input  rgb18_t       solid_color_i,
    input  logic [3:0]   vga_r_i,
    input  logic [3:0]   vga_g_i,
    input  logic [3:0]   vga_b_i,
    input  logic         vga_hsync_i,
    input  logic         vga_vsync_i,
    input  logic         test_end_i,
    input  int           test_id_i,
    input  logic         run_end_i,
    output int           err_count_o,
    output logic         report_done_o
);

    // DAC fields are drive masks, 1 where the leg is pulled high
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
        logic       hsync;
        logic       vsync;
    } pin_state_t;

    localparam pin_state_t IDLE_PINS = '{r: 4'h0, g: 4'h0, b: 4'h0, hsync: 1'b1, vsync: 1'b1};

    int         model_x          = 0;
    int         model_y          = 0;
    pin_state_t stage_exp        = IDLE_PINS;
    pin_state_t pin_exp          = IDLE_PINS;
    logic       primed           = 1'b0;
    logic       report_done      = 1'b0;
    int         error_total      = 0;
    int         check_total      = 0;
    int         hsync_low_run    = 0;
    int         vsync_low_run    = 0;
    int         tests_done       = 0;
    int         checks_at_report = 0;
    int         errors_at_report = 0;

    assign err_count_o   = error_total;
    assign report_done_o = report_done;

    function automatic string test_title(input int id);
        case (id)
            1: return "reset and idle";
            2: return "sync timing";
            3: return "solid random colours";
            4: return "bars pattern";
            5: return "gradient pattern";
            6: return "checker pattern";
            7: return "saturation";
            default: return "unknown test";
        endcase
    endfunction

    function automatic logic [3:0] dither_drive(input int level, input int x, input int y);
        int threshold;
        int code;
        // Ordered 2x2 thresholds, row-major 0 2 3 1
        case ((y % 2) * 2 + (x % 2))
            0: threshold = 0;
            1: threshold = 2;
            2: threshold = 3;
            default: threshold = 1;
        endcase
        code = level / 4;
        if (level % 4 > threshold) begin
            code = code + 1;
        end
        if (code > 15) begin
            code = 15;
        end
        return code[3:0];
    endfunction

    function automatic pin_state_t predict_pins(
        input int           x,
        input int           y,
        input pattern_sel_t sel,
        input rgb18_t       solid
    );
        pin_state_t pins;
        int         red;
        int         green;
        int         blue;
        int         hs_start;
        int         vs_start;
        hs_start   = H_VISIBLE + H_FRONT;
        vs_start   = V_VISIBLE + V_FRONT;
        // Syncs are active low
        pins.hsync = !(x >= hs_start && x < hs_start + H_SYNC);
        pins.vsync = !(y >= vs_start && y < vs_start + V_SYNC);
        pins.r     = 4'h0;
        pins.g     = 4'h0;
        pins.b     = 4'h0;
        if (x < H_VISIBLE && y < V_VISIBLE) begin
            case (sel)
                PAT_BARS: begin
                    red   = ((x / 2) & 4) != 0 ? 63 : 0;
                    green = ((x / 2) & 2) != 0 ? 63 : 0;
                    blue  = ((x / 2) & 1) != 0 ? 63 : 0;
                end
                PAT_GRADIENT: begin
                    red   = x * 4;
                    green = y * 8;
                    blue  = 63 - x * 4;
                end
                PAT_CHECKER: begin
                    red   = (((x / 2) ^ (y / 2)) & 1) != 0 ? 63 : 0;
                    green = red;
                    blue  = red;
                end
                default: begin
                    red   = int'(solid.red);
                    green = int'(solid.green);
                    blue  = int'(solid.blue);
                end
            endcase
            pins.r = dither_drive(red, x, y);
            pins.g = dither_drive(green, x, y);
            pins.b = dither_drive(blue, x, y);
        end
        return pins;
    endfunction

    task automatic check_dac(input string name, input logic [3:0] expected, input logic [3:0] pins);
        logic [3:0] driven;
        string      shown;
        shown = "";
        for (int i = 3; i >= 0; i--) begin
            // Released legs read as z
            driven[i] = (pins[i] === 1'b1);
            if (expected[i]) begin
                shown = {shown, "1"};
            end else begin
                shown = {shown, "z"};
            end
        end
        check_total++;
        if (driven !== expected) begin
            $display("Mismatch at %0t ns: %s expected %s got %b", $time, name, shown, pins);
            error_total++;
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        check_total++;
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s expected %b got %b", $time, name, expected, actual);
            error_total++;
        end
    endtask

    task automatic track_pulse(
        input string name,
        input logic  level,
        input int    expected,
        inout int    run
    );
        if (level === 1'b0) begin
            run++;
        end else if (run != 0) begin
            check_total++;
            if (run != expected) begin
                $display("Mismatch at %0t ns: %s low pulse expected %0d clocks got %0d",
                         $time, name, expected, run);
                error_total++;
            end
            run = 0;
        end
    endtask

    // Pins show the position captured two rising edges earlier
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            model_x   = 0;
            model_y   = 0;
            stage_exp = IDLE_PINS;
            pin_exp   = IDLE_PINS;
            primed    = 1'b1;
        end else begin
            pin_exp   = stage_exp;
            stage_exp = predict_pins(model_x, model_y, pattern_sel_i, solid_color_i);
            if (model_x == H_TOTAL - 1) begin
                model_x = 0;
                model_y = (model_y == V_TOTAL - 1) ? 0 : model_y + 1;
            end else begin
                model_x = model_x + 1;
            end
        end
        if (test_end_i) begin
            tests_done++;
            $display("%s: %0d checks, %0d errors", test_title(test_id_i),
                     check_total - checks_at_report, error_total - errors_at_report);
            checks_at_report = check_total;
            errors_at_report = error_total;
        end
        if (run_end_i && !report_done) begin
            $display("Summary: %0d tests, %0d checks, %0d errors",
                     tests_done, check_total, error_total);
            report_done = 1'b1;
        end
    end

    always @(negedge clk_i) begin
        if (primed && !report_done) begin
            check_dac("vga_r_io", pin_exp.r, vga_r_i);
            check_dac("vga_g_io", pin_exp.g, vga_g_i);
            check_dac("vga_b_io", pin_exp.b, vga_b_i);
            check_level("vga_hsync_o", pin_exp.hsync, vga_hsync_i);
            check_level("vga_vsync_o", pin_exp.vsync, vga_vsync_i);
            track_pulse("vga_hsync_o", vga_hsync_i, H_SYNC, hsync_low_run);
            track_pulse("vga_vsync_o", vga_vsync_i, V_SYNC * H_TOTAL, vsync_low_run);
        end
    end

endmodule

// ==== test/vga_display_tb.sv ====
`timescale 1ns/1ns

module vga_display_tb import vga_timing_pkg::*, vga_color_pkg::*; ();

    localparam int          CLK_PERIOD    = 10;
    localparam int          FRAME_CLOCKS  = H_TOTAL * V_TOTAL;
    localparam int          PIPE_CLOCKS   = 2;
    localparam int          RANDOM_COLORS = 8;
    localparam int          COLOR_HOLD    = 72;
    localparam logic [31:0] SEED          = 32'h3f61_5a64;

    // One line plus eight frames of stimulus, rounded up
    localparam int TEST_FRAMES   = 9;
    localparam int MARGIN_CLOCKS = 100;
    localparam int WATCHDOG_NS   = (TEST_FRAMES * FRAME_CLOCKS + MARGIN_CLOCKS) * CLK_PERIOD;

    logic         clk;
    logic         rst_n;
    pattern_sel_t pattern_sel;
    rgb18_t       solid_color;
    wire  [3:0]   vga_r;
    wire  [3:0]   vga_g;
    wire  [3:0]   vga_b;
    logic         vga_hsync;
    logic         vga_vsync;
    logic         test_end;
    int           test_id;
    logic         run_end;
    int           err_count;
    logic         report_done;

    tb_clock_gen u_clock (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    vga_display_top uut (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .pattern_sel_i (pattern_sel),
        .solid_color_i (solid_color),
        .vga_r_io      (vga_r),
        .vga_g_io      (vga_g),
        .vga_b_io      (vga_b),
        .vga_hsync_o   (vga_hsync),
        .vga_vsync_o   (vga_vsync)
    );

    vga_scoreboard u_scoreboard (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .pattern_sel_i (pattern_sel),
        .solid_color_i (solid_color),
        .vga_r_i       (vga_r),
        .vga_g_i       (vga_g),
        .vga_b_i       (vga_b),
        .vga_hsync_i   (vga_hsync),
        .vga_vsync_i   (vga_vsync),
        .test_end_i    (test_end),
        .test_id_i     (test_id),
        .run_end_i     (run_end),
        .err_count_o   (err_count),
        .report_done_o (report_done)
    );

    task automatic run_clocks(input int count);
        repeat (count) @(negedge clk);
    endtask

    // Let the last positions reach the pins, then mark the test boundary
    task automatic end_test(input int id);
        repeat (PIPE_CLOCKS) @(negedge clk);
        test_id  = id;
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    function automatic rgb18_t random_color();
        rgb18_t color;
        color.red   = level6_t'($urandom % 64);
        color.green = level6_t'($urandom % 64);
        color.blue  = level6_t'($urandom % 64);
        return color;
    endfunction

    initial begin
        void'($urandom(SEED));
        pattern_sel = PAT_SOLID;
        solid_color = '{red: 6'd0, green: 6'd0, blue: 6'd0};
        test_end    = 1'b0;
        test_id     = 0;
        run_end     = 1'b0;

        wait (rst_n);
        @(negedge clk);
        run_clocks(H_TOTAL);
        end_test(1);

        solid_color = '{red: 6'd32, green: 6'd21, blue: 6'd10};
        run_clocks(2 * FRAME_CLOCKS);
        end_test(2);

        // Colour changes land mid-frame on purpose
        for (int n = 0; n < RANDOM_COLORS; n++) begin
            solid_color = random_color();
            run_clocks(COLOR_HOLD);
        end
        end_test(3);

        pattern_sel = PAT_BARS;
        run_clocks(FRAME_CLOCKS);
        end_test(4);

        pattern_sel = PAT_GRADIENT;
        run_clocks(FRAME_CLOCKS);
        end_test(5);

        pattern_sel = PAT_CHECKER;
        run_clocks(FRAME_CLOCKS);
        end_test(6);

        pattern_sel = PAT_SOLID;
        solid_color = '{red: 6'd63, green: 6'd63, blue: 6'd63};
        run_clocks(FRAME_CLOCKS);
        end_test(7);

        run_end = 1'b1;
        wait (report_done);
        @(negedge clk);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
logic/vga_timing_pkg.sv
logic/vga_color_pkg.sv
logic/vga_timing.sv
logic/vga_pattern_source.sv
logic/vga_dither_channel.sv
logic/vga_pad_bank.sv
logic/vga_display_top.sv
test/tb_clock_gen.sv
test/vga_scoreboard.sv
test/vga_display_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the VGA display testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module vga_display_tb \
    -o vga_display_sim > build.log 2>&1 \
    && ./obj_dir/vga_display_sim > "$LOG" 2>&1 \
    || { cat build.log "$LOG" 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat "$LOG"
grep -q "Test FAILED" "$LOG" && { echo "Simulation reported failure"; exit 1; }
exit 0
